// ==== src.f ====
+incdir+dv
src/vga_pkg.sv
src/line_capture.sv
src/line_buffer.sv
src/vga_timing.sv
src/vga_scan_doubler.sv
dv/tb_vga_scan_doubler.sv

// ==== dv/vga_model.svh ====
`ifndef VGA_MODEL_SVH
`define VGA_MODEL_SVH

// reference state of the scan doubler, advanced once per rising clock edge
int           phase_idx;
logic         wr_bank_m;
logic         fill_bank_m;
vic_color     line_mem [2][buf_depth];
vic_color     rd_color_m;
logic         step_m;
scan_count_t  h_m;
scan_count_t  v_m;
logic         hsync_m;
logic         vsync_m;
logic         active_m;
scan_timing_t tm_m;
int           frame_starts;

// inputs are the values the DUT samples at the same edge
task automatic advance_model(
   input logic      rst_in,
   input chip_t     chip_in,
   input raster_x_t x,
   input raster_y_t y,
   input vic_color  c
);
   scan_timing_t chip_tm;
   logic         we;
   logic         bank_next;
   logic         origin;
   logic         h_wrap;
   logic         blank;
   scan_count_t  addr;

   chip_tm = timing_for_chip(chip_in);
   if (rst_in) begin
      phase_idx   = 3;
      wr_bank_m   = 1'b0;
      fill_bank_m = 1'b0;
      rd_color_m  = black;
      step_m      = 1'b0;
      h_m         = '0;
      v_m         = chip_tm.max_height - chip_tm.voffset;
      hsync_m     = 1'b1;
      vsync_m     = 1'b1;
      active_m    = 1'b0;
      tm_m        = chip_tm;
   end else begin
      we        = (phase_idx == 0);
      bank_next = (x == '0) ? ~wr_bank_m : wr_bank_m;
      origin    = we && (x == '0) && (y == '0);
      h_wrap    = (h_m >= tm_m.max_width);
      blank     = (h_m < tm_m.hoffset);
      addr      = h_m - tm_m.hoffset;

      // outputs follow the counter state before this edge
      hsync_m  = !((h_m >= tm_m.hs_sta) && (h_m < tm_m.hs_end));
      vsync_m  = !((v_m >= tm_m.vs_sta) && (v_m < tm_m.vs_end));
      active_m = (h_m >= tm_m.ha_sta) && (v_m < tm_m.va_end);

      // the read sees the line memory before this edge's write
      if (blank) begin
         rd_color_m = black;
      end else if (fill_bank_m) begin
         rd_color_m = line_mem[0][addr];
      end else begin
         rd_color_m = line_mem[1][addr];
      end

      if (we) begin
         line_mem[bank_next][x] = c;
         fill_bank_m = bank_next;
         wr_bank_m   = bank_next;
      end

      if (origin) begin
         v_m = tm_m.max_height - tm_m.voffset;
         frame_starts++;
      end else if (step_m && h_wrap) begin
         v_m = (v_m < tm_m.max_height) ? v_m + 1'b1 : '0;
      end
      if (step_m) begin
         h_m = h_wrap ? '0 : h_m + 1'b1;
      end

      step_m    = ~step_m;
      phase_idx = (phase_idx + 1) % 4;
   end
endtask

// pixel is only passed through while the registered active is high
function automatic vic_color expected_pixel();
   return active_m ? rd_color_m : black;
endfunction

`endif

// ==== dv/tb_vga_scan_doubler.sv ====
`timescale 1ns/1ps

module tb_vga_scan_doubler;

   import vga_pkg::*;

   logic      clk_dot4x = 1'b0;
   logic      rst;
   chip_t     chip;
   raster_x_t raster_x;
   raster_y_t raster_y;
   vic_color  pixel_color;
   logic      hsync;
   logic      vsync;
   logic      active;
   vic_color  pixel_out;

   // source generator
   int src_div;
   int line_len;
   int frame_lines;

   // run bookkeeping
   int   cycle;
   int   last_hsync_fall;
   logic prev_hsync;
   int   lit_pixels;
   // outputs must stay idle in reset and right after release
   logic idle_expected;

   `include "vga_model.svh"

   vga_scan_doubler dut (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .chip        (chip),
      .raster_x    (raster_x),
      .raster_y    (raster_y),
      .pixel_color (pixel_color),
      .hsync       (hsync),
      .vsync       (vsync),
      .active      (active),
      .pixel_out   (pixel_out)
   );

   initial begin
      forever #5 clk_dot4x = ~clk_dot4x;
   end

   task automatic compare_value(
      input logic [31:0] actual,
      input logic [31:0] expected,
      input string       what
   );
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                  $time, what, actual, expected);
         $display("Testbench failed");
         $fatal(1, "stopping at the first error");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timed out at %0t ns while waiting for %s", $time, what);
      $display("Testbench failed");
      $fatal(1, "stopping on a timeout");
   endtask

   // line lengths scatter just below the chip's line width
   function automatic int random_line_len();
      scan_timing_t t;
      t = timing_for_chip(chip);
      return int'(t.max_width) + 1 - int'($urandom % 17);
   endfunction

   // new dot every four clocks from reset release
   task automatic drive_source();
      if (rst) begin
         src_div     = 0;
         raster_x    = '0;
         raster_y    = '0;
         line_len    = random_line_len();
         pixel_color = vic_color'($urandom);
      end else begin
         src_div++;
         if (src_div == 4) begin
            src_div = 0;
            if (int'(raster_x) + 1 >= line_len) begin
               raster_x = '0;
               line_len = random_line_len();
               if (int'(raster_y) + 1 >= frame_lines) begin
                  raster_y = '0;
               end else begin
                  raster_y = raster_y + 1'b1;
               end
            end else begin
               raster_x = raster_x + 1'b1;
            end
            pixel_color = vic_color'($urandom);
         end
      end
   endtask

   // one clock of checks and model update, then the next inputs
   task automatic tick();
      @(negedge clk_dot4x);
      if (idle_expected) begin
         check_idle_outputs();
      end
      if (!active) begin
         compare_value(pixel_out, black, "pixel_out outside active video");
      end
      advance_model(rst, chip, raster_x, raster_y, pixel_color);
      cycle++;
      compare_value(hsync, hsync_m, "hsync");
      compare_value(vsync, vsync_m, "vsync");
      compare_value(active, active_m, "active");
      compare_value(pixel_out, expected_pixel(), "pixel_out");
      if (active && (pixel_out !== black) && (^pixel_out !== 1'bx)) begin
         lit_pixels++;
      end
      if ((prev_hsync === 1'b1) && (hsync === 1'b0)) begin
         last_hsync_fall = cycle;
      end
      prev_hsync = hsync;
      drive_source();
   endtask

   task automatic check_idle_outputs();
      compare_value(hsync, 1'b1, "hsync idle around reset");
      compare_value(vsync, 1'b1, "vsync idle around reset");
      compare_value(active, 1'b0, "active idle around reset");
      compare_value(pixel_out, black, "pixel_out idle around reset");
   endtask

   task automatic apply_reset();
      rst           = 1'b1;
      idle_expected = 1'b1;
      frame_starts  = 0;
      lit_pixels    = 0;
      repeat (8) tick();
      rst = 1'b0;
      // first counter step lands on the second clock after release
      repeat (2) tick();
      idle_expected = 1'b0;
   endtask

   task automatic wait_hsync(input logic level, input int limit);
      int n;
      n = 0;
      while (hsync !== level) begin
         if (n >= limit) begin
            report_timeout(level ? "hsync to rise" : "hsync to fall");
         end
         tick();
         n++;
      end
   endtask

   task automatic wait_active(input logic level, input int limit);
      int n;
      n = 0;
      while (active !== level) begin
         if (n >= limit) begin
            report_timeout(level ? "active to rise" : "active to fall");
         end
         tick();
         n++;
      end
   endtask

   task automatic wait_frame_starts(input int count, input int limit);
      int n;
      n = 0;
      while (frame_starts < count) begin
         if (n >= limit) begin
            report_timeout("the next frame origin from the source");
         end
         tick();
         n++;
      end
   endtask

   // sync width, line period and start of active video in clocks
   task automatic measure_horizontal();
      scan_timing_t t;
      int           fall_cycle;
      t = timing_for_chip(chip);
      wait_hsync(1'b1, 2500);
      wait_hsync(1'b0, 2500);
      fall_cycle = cycle;
      wait_hsync(1'b1, 2500);
      compare_value(cycle - fall_cycle, (t.hs_end - t.hs_sta) * 2, "hsync low width");
      wait_hsync(1'b0, 2500);
      compare_value(cycle - fall_cycle, (t.max_width + 1) * 2, "line period");
      wait_active(1'b0, 2500);
      wait_active(1'b1, 100000);
      compare_value(cycle - last_hsync_fall, (t.ha_sta - t.hs_sta) * 2,
                    "active start after hsync fall");
   endtask

   initial begin
      chip_t        chips [3];
      scan_timing_t t;

      void'($urandom(32'h193e486f));
      chips           = '{chip6569, chip6567r8, chip6567r56a};
      rst             = 1'b1;
      chip            = chips[0];
      raster_x        = '0;
      raster_y        = '0;
      pixel_color     = black;
      src_div         = 0;
      line_len        = 504;
      frame_lines     = 312;
      cycle           = 0;
      last_hsync_fall = 0;
      prev_hsync      = 1'b1;
      lit_pixels      = 0;
      frame_starts    = 0;
      idle_expected   = 1'b0;

      for (int i = 0; i < 3; i++) begin
         chip        = chips[i];
         t           = timing_for_chip(chip);
         // two output lines per input line fill one output frame
         frame_lines = (int'(t.max_height) + 1) / 2;
         apply_reset();
         measure_horizontal();
         wait_frame_starts(2, 2000000);
         repeat (4000) tick();
         compare_value(lit_pixels != 0, 1'b1, "lit pixels in active video");
      end

      $display("Testbench passed");
      $finish;
   end

endmodule : tb_vga_scan_doubler

// ==== src/vga_scan_doubler.sv ====
`timescale 1ns/1ps

module vga_scan_doubler (
   input  logic               clk_dot4x,
   input  logic               rst,
   input  vga_pkg::chip_t     chip,
   input  vga_pkg::raster_x_t raster_x,
   input  vga_pkg::raster_y_t raster_y,
   input  vga_pkg::vic_color  pixel_color,
   output logic               hsync,
   output logic               vsync,
   output logic               active,
   output vga_pkg::vic_color  pixel_out
);

   import vga_pkg::*;

   line_write_t wr;
   logic        frame_start;
   buf_addr_t   rd_addr;
   logic        rd_blank;
   vic_color    rd_color;

   // incoming dots into write requests
   line_capture u_line_capture (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .raster_x    (raster_x),
      .raster_y    (raster_y),
      .pixel_color (pixel_color),
      .wr          (wr),
      .frame_start (frame_start)
   );

   // ping-pong storage of one input line
   line_buffer u_line_buffer (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .wr        (wr),
      .rd_addr   (rd_addr),
      .rd_blank  (rd_blank),
      .rd_color  (rd_color)
   );

   // output raster, each stored line drawn twice
   vga_timing u_vga_timing (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .chip        (chip),
      .frame_start (frame_start),
      .rd_addr     (rd_addr),
      .rd_blank    (rd_blank),
      .rd_color    (rd_color),
      .hsync       (hsync),
      .vsync       (vsync),
      .active      (active),
      .pixel_out   (pixel_out)
   );

endmodule : vga_scan_doubler

// ==== src/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing (
   input  logic               clk_dot4x,
   input  logic               rst,
   input  vga_pkg::chip_t     chip,
   input  logic               frame_start,
   output vga_pkg::buf_addr_t rd_addr,
   output logic               rd_blank,
   input  vga_pkg::vic_color  rd_color,
   output logic               hsync,
   output logic               vsync,
   output logic               active,
   output vga_pkg::vic_color  pixel_out
);

   import vga_pkg::*;

   // timing for the chip currently on the chip input
   scan_timing_t chip_tm;
   // timing held for the whole run, taken while reset is asserted
   scan_timing_t tm;

   scan_count_t h_count;
   scan_count_t v_count;
   scan_count_t v_reload;
   logic        step;
   logic        h_wrap;

   // raw outputs derived from the counters
   logic        hsync_raw;
   logic        vsync_raw;
   logic        active_raw;

   assign chip_tm = timing_for_chip(chip);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         tm <= chip_tm;
      end
   end

   // counters run at half the clock rate, twice the input dot rate
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         step <= 1'b0;
      end else begin
         step <= ~step;
      end
   end

   assign h_wrap = (h_count >= tm.max_width);

   // start of frame on the output lags the source by voffset lines
   assign v_reload = tm.max_height - tm.voffset;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         h_count <= '0;
      end else if (step) begin
         if (h_wrap) begin
            h_count <= '0;
         end else begin
            h_count <= h_count + scan_count_t'(1);
         end
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         v_count <= chip_tm.max_height - chip_tm.voffset;
      end else if (frame_start) begin
         // realign to the incoming frame, overrides a step
         v_count <= v_reload;
      end else if (step && h_wrap) begin
         if (v_count < tm.max_height) begin
            v_count <= v_count + scan_count_t'(1);
         end else begin
            v_count <= '0;
         end
      end
   end

   // sync pulses are active low, end value excluded
   assign hsync_raw  = ~((h_count >= tm.hs_sta) && (h_count < tm.hs_end));
   assign vsync_raw  = ~((v_count >= tm.vs_sta) && (v_count < tm.vs_end));
   assign active_raw = (h_count >= tm.ha_sta) && (v_count < tm.va_end);

   // buffer read for the current output position
   assign rd_blank = (h_count < tm.hoffset);
   assign rd_addr  = buf_addr_t'(h_count - tm.hoffset);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         active <= 1'b0;
      end else begin
         hsync  <= hsync_raw;
         vsync  <= vsync_raw;
         active <= active_raw;
      end
   end

   // rd_color and active both lag the counters by one clock
   assign pixel_out = active ? rd_color : black;

endmodule : vga_timing

// ==== src/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  vga_pkg::line_write_t wr,
   input  vga_pkg::buf_addr_t   rd_addr,
   input  logic                 rd_blank,
   output vga_pkg::vic_color    rd_color
);

   import vga_pkg::*;

   (* ram_style = "block" *) vic_color bank0_mem [buf_depth];
   (* ram_style = "block" *) vic_color bank1_mem [buf_depth];

   // bank currently being filled by the capture side
   logic fill_bank;

   always_ff @(posedge clk_dot4x) begin
      if (wr.we) begin
         if (wr.bank) begin
            bank1_mem[wr.addr] <= wr.color;
         end else begin
            bank0_mem[wr.addr] <= wr.color;
         end
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         fill_bank <= 1'b0;
      end else if (wr.we) begin
         fill_bank <= wr.bank;
      end
   end

   // readout always comes from the last completed line
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         rd_color <= black;
      end else if (rd_blank) begin
         rd_color <= black;
      end else if (fill_bank) begin
         rd_color <= bank0_mem[rd_addr];
      end else begin
         rd_color <= bank1_mem[rd_addr];
      end
   end

endmodule : line_buffer

// ==== src/line_capture.sv ====
`timescale 1ns/1ps

module line_capture (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  vga_pkg::raster_x_t   raster_x,
   input  vga_pkg::raster_y_t   raster_y,
   input  vga_pkg::vic_color    pixel_color,
   output vga_pkg::line_write_t wr,
   output logic                 frame_start
);

   import vga_pkg::*;

   // one-hot dot phase ring, bit 0 marks the clock with a stable dot
   logic [3:0] phase;
   logic       bank_q;
   logic       line_start;
   logic       bank_next;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phase <= 4'b1000;
      end else begin
         phase <= {phase[2:0], phase[3]};
      end
   end

   assign line_start = (raster_x == raster_x_t'(0));

   // switch banks at the first dot of every line
   assign bank_next = line_start ? ~bank_q : bank_q;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         bank_q <= 1'b0;
      end else if (phase[0]) begin
         bank_q <= bank_next;
      end
   end

   always_comb begin
      wr.we    = phase[0];
      wr.bank  = bank_next;
      wr.addr  = buf_addr_t'(raster_x);
      wr.color = pixel_color;
   end

   // raster origin seen by the source
   assign frame_start = phase[0] && line_start && (raster_y == raster_y_t'(0));

endmodule : line_capture

// ==== src/vga_pkg.sv ====
package vga_pkg;

   // one pixel, a palette index as produced by the video chip
   typedef logic [3:0] vic_color;

   // blank pixel
   localparam vic_color black = 4'd0;

   // raster position as delivered by the source
   typedef logic [9:0] raster_x_t;
   typedef logic [8:0] raster_y_t;

   // output side horizontal and vertical counters
   typedef logic [9:0] scan_count_t;

   typedef enum logic [1:0] {
      chip6567r8   = 2'd0,
      chip6569     = 2'd1,
      chip6567r56a = 2'd2,
      chipunused   = 2'd3
   } chip_t;

   // pixels per bank, enough for the widest line (6567R8)
   localparam int buf_depth = 520;

   typedef logic [9:0] buf_addr_t;

   // one write request into the line buffer
   typedef struct packed {
      logic      we;
      logic      bank;
      buf_addr_t addr;
      vic_color  color;
   } line_write_t;

   // timing values for one chip model, all in output counter steps
   typedef struct packed {
      scan_count_t max_width;
      scan_count_t max_height;
      scan_count_t hs_sta;
      scan_count_t hs_end;
      scan_count_t ha_sta;
      scan_count_t vs_sta;
      scan_count_t vs_end;
      scan_count_t va_end;
      scan_count_t hoffset;
      scan_count_t voffset;
   } scan_timing_t;

   function automatic scan_timing_t timing_for_chip(input chip_t chip);
      scan_timing_t t;
      case (chip)
         chip6567r8: begin
            t.max_width  = 10'd519;
            t.max_height = 10'd525;
            // h porch 10, sync 62, back porch 31
            t.hs_sta     = 10'd10;
            t.hs_end     = 10'd72;
            t.ha_sta     = 10'd103;
            // v front porch 10, sync 3, back porch 11
            t.vs_sta     = 10'd512;
            t.vs_end     = 10'd515;
            t.va_end     = 10'd502;
            t.hoffset    = 10'd20;
            t.voffset    = 10'd52;
         end
         chip6567r56a: begin
            t.max_width  = 10'd511;
            t.max_height = 10'd523;
            // h porch 10, sync 61, back porch 31
            t.hs_sta     = 10'd10;
            t.hs_end     = 10'd71;
            t.ha_sta     = 10'd102;
            // v front porch 10, sync 3, back porch 9
            t.vs_sta     = 10'd512;
            t.vs_end     = 10'd515;
            t.va_end     = 10'd502;
            t.hoffset    = 10'd20;
            t.voffset    = 10'd52;
         end
         default: begin
            // 6569 and the unused code share the PAL timing
            t.max_width  = 10'd503;
            t.max_height = 10'd623;
            t.hs_sta     = 10'd10;
            t.hs_end     = 10'd70;
            t.ha_sta     = 10'd100;
            // v front porch 11, sync 3, back porch 41
            t.vs_sta     = 10'd580;
            t.vs_end     = 10'd583;
            t.va_end     = 10'd569;
            t.hoffset    = 10'd10;
            t.voffset    = 10'd20;
         end
      endcase
      return t;
   endfunction

endpackage : vga_pkg
